//--- fetch_params.svh
////////////////////////////////////////////////////////////
// Architectural constants of the fetch stage
// Include wherever a width, depth or encoding is needed
////////////////////////////////////////////////////////////
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction and PC width
`define WORD_W 16

// Instruction memory depth in words
`define IMEM_WORDS 256
`define IMEM_AW $clog2(`IMEM_WORDS)

// Decode destinations remembered for RAW checks
`define RAW_WINDOW 3

// Edges from halt issue to dump request
`define DUMP_DELAY 5

// Bubble encoding
`define NOP_WORD 16'h0800

`endif

//--- fetch_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the fetch stage
// Referenced by scoped name from every RTL file
////////////////////////////////////////////////////////////
`include "fetch_params.svh"

package fetch_pkg;

   ////////////////////////////////////////////////////////////
   // Instruction word
   ////////////////////////////////////////////////////////////

   // Register format with function field
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;
   } r_fmt_t;

   // Immediate format
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [4:0] imm;
   } i_fmt_t;

   // Same 16 bits seen through either format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_t;

   ////////////////////////////////////////////////////////////
   // Stage payloads
   ////////////////////////////////////////////////////////////

   // Destination register reported by decode
   typedef struct packed {
      logic       valid;
      logic [2:0] idx;
   } reg_dst_t;

   // Word handed to decode with its incremented PC
   typedef struct packed {
      instr_t              instr;
      logic [`WORD_W-1:0] pc_p2;
   } fetch_out_t;

endpackage

//--- instr_mem.sv
////////////////////////////////////////////////////////////
// Word-organized instruction memory
// Asynchronous read for fetch, clocked write for program load
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_mem (
   input  logic                      clk,
   input  logic [`IMEM_AW-1:0]       word_addr,
   output fetch_pkg::instr_t         rd_data,
   input  logic                      prog_we,
   input  logic [`IMEM_AW-1:0]       prog_addr,
   input  fetch_pkg::instr_t         prog_data
);

   // Storage array
   // No reset, contents come from the load port
   fetch_pkg::instr_t mem [`IMEM_WORDS];

   ////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////

   // Zero-cycle read at the current word address
   assign rd_data = mem[word_addr];

   ////////////////////////////////////////////////////////////
   // Load side
   ////////////////////////////////////////////////////////////

   // Write lands on the edge
   // Visible to the read port right after
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

endmodule

//--- raw_hazard_detector.sv
////////////////////////////////////////////////////////////
// Read-after-write check for the word being fetched
// Compares used sources against recent decode destinations
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module raw_hazard_detector (
   input  logic                clk,
   input  logic                arst_n,
   input  fetch_pkg::instr_t   instr,
   input  fetch_pkg::reg_dst_t dec_dst,
   output logic                raw_stall
);

   logic [4:0] opcode;
   logic       is_r_fmt;
   logic [2:0] rs;
   logic [2:0] rt;
   logic       rs_used;
   logic       rt_used;
   logic       rs_hit;
   logic       rt_hit;

   // Older decode destinations, entry 0 is one cycle back
   fetch_pkg::reg_dst_t hist_q [`RAW_WINDOW-1];

   ////////////////////////////////////////////////////////////
   // Source field decode
   ////////////////////////////////////////////////////////////

   assign opcode   = instr.i_fmt.opcode;

   // Register-register group
   assign is_r_fmt = (opcode[4:1] == 4'b1101);

   // Source fields sit at the same bits in both formats
   assign rs = instr.i_fmt.rs;
   assign rt = instr.i_fmt.rt;

   // No rs for halt/nop/misc group or for immediate jumps
   assign rs_used = (opcode[4:2] != 3'b000) &&
                    ({opcode[4:2], opcode[0]} != 4'b0010);

   // rt read by R-type ALU ops and by stores/compares
   assign rt_used = is_r_fmt || (opcode[4:2] == 3'b111);

   ////////////////////////////////////////////////////////////
   // Destination history
   ////////////////////////////////////////////////////////////

   // Shifts every cycle, stalls included
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `RAW_WINDOW-1; i++) begin
            hist_q[i] <= '0;
         end
      end else begin
         hist_q[0] <= dec_dst;
         for (int i = 1; i < `RAW_WINDOW-1; i++) begin
            hist_q[i] <= hist_q[i-1];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Match
   ////////////////////////////////////////////////////////////

   // Current decode destination counts as the newest entry
   always_comb begin
      rs_hit = dec_dst.valid && (dec_dst.idx == rs);
      rt_hit = dec_dst.valid && (dec_dst.idx == rt);
      for (int i = 0; i < `RAW_WINDOW-1; i++) begin
         rs_hit = rs_hit || (hist_q[i].valid && (hist_q[i].idx == rs));
         rt_hit = rt_hit || (hist_q[i].valid && (hist_q[i].idx == rt));
      end
   end

   assign raw_stall = (rs_used && rs_hit) || (rt_used && rt_hit);

   // Halt, NOP and immediate-jump words read no register
   a_no_stall_without_src: assert property (
      @(posedge clk) disable iff (!arst_n)
      ((opcode[4:2] == 3'b000) || ({opcode[4:2], opcode[0]} == 4'b0010))
         |-> !raw_stall
   );

endmodule

//--- fetch.sv
////////////////////////////////////////////////////////////
// Fetch control with PC, bubbles, halt and dump request
// Registers the issued word or a NOP toward decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   pc_src,
   input  logic [`WORD_W-1:0]     jump_pc,
   output logic [`IMEM_AW-1:0]    word_addr,
   input  fetch_pkg::instr_t      instr,
   input  logic                   raw_stall,
   output fetch_pkg::fetch_out_t  fetch_out,
   output logic                   halted,
   output logic                   dump
);

   // PC wraps over twice the memory depth in bytes
   localparam logic [`WORD_W-1:0] PC_MASK = `WORD_W'(2 * `IMEM_WORDS - 1);

   logic [`WORD_W-1:0]    pc_q;
   logic [`WORD_W-1:0]    pc_p2;
   logic [`WORD_W-1:0]    pc_next;
   logic [4:0]            opcode;
   logic                  is_ctrl;
   logic                  is_halt;
   logic                  shadow_q;
   logic                  bubble;
   logic                  issue;
   logic                  halted_q;
   logic [`DUMP_DELAY-1:0] dump_sr;
   fetch_pkg::fetch_out_t out_d;

   ////////////////////////////////////////////////////////////
   // Decode of the fetched word
   ////////////////////////////////////////////////////////////

   // Opcode is common to both formats
   assign opcode  = instr.r_fmt.opcode;

   // Jump group 001xx and branch group 011xx
   assign is_ctrl = (opcode[4:2] == 3'b001) || (opcode[4:2] == 3'b011);
   assign is_halt = (opcode == 5'b00000);

   ////////////////////////////////////////////////////////////
   // Issue decision
   ////////////////////////////////////////////////////////////

   // Hazard or the slot right after a jump/branch
   assign bubble = raw_stall || shadow_q;

   // Nothing goes out once halted
   assign issue  = !bubble && !halted_q;

   ////////////////////////////////////////////////////////////
   // Program counter
   ////////////////////////////////////////////////////////////

   assign pc_p2     = (pc_q + `WORD_W'(2)) & PC_MASK;

   // Redirect only counts on an issue cycle
   assign pc_next   = (pc_src ? jump_pc : pc_p2) & PC_MASK;

   // Byte PC to word index
   assign word_addr = pc_q[`IMEM_AW:1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= '0;
      end else if (issue) begin
         pc_q <= pc_next;
      end
   end

   ////////////////////////////////////////////////////////////
   // Control shadow and halt
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         shadow_q <= 1'b0;
         halted_q <= 1'b0;
      end else begin
         // One bubble after every issued jump/branch
         shadow_q <= issue && is_ctrl;
         // Sticky until reset
         halted_q <= halted_q || (issue && is_halt);
      end
   end

   // Dump delay line fed by the halted level
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dump_sr <= '0;
      end else begin
         dump_sr <= {dump_sr[`DUMP_DELAY-2:0], halted_q};
      end
   end

   assign halted = halted_q;
   assign dump   = dump_sr[`DUMP_DELAY-1];

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////

   // Issued word or NOP, always with PC+2
   assign out_d.instr = issue ? instr : fetch_pkg::instr_t'(`NOP_WORD);
   assign out_d.pc_p2 = pc_p2;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_out.instr <= fetch_pkg::instr_t'(`NOP_WORD);
         fetch_out.pc_p2 <= '0;
      end else begin
         fetch_out <= out_d;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_pc_even: assert property (
      @(posedge clk) disable iff (!arst_n)
      pc_q[0] == 1'b0
   );

   // Dump rises exactly DUMP_DELAY edges after halted rose
   a_dump_after_halt: assert property (
      @(posedge clk) disable iff (!arst_n)
      $rose(dump) |-> $past(halted, `DUMP_DELAY) && !$past(halted, `DUMP_DELAY + 1)
   );

   // Halt word itself goes out, then only NOPs
   a_nop_when_halted: assert property (
      @(posedge clk) disable iff (!arst_n)
      halted |=> (fetch_out.instr == `NOP_WORD)
   );

endmodule

//--- fetch_subsystem.sv
////////////////////////////////////////////////////////////
// Fetch stage top with memory, RAW detector and control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_subsystem (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  pc_src,
   input  logic [`WORD_W-1:0]    jump_pc,
   input  fetch_pkg::reg_dst_t   dec_dst,
   input  logic                  prog_we,
   input  logic [`IMEM_AW-1:0]   prog_addr,
   input  fetch_pkg::instr_t     prog_data,
   output fetch_pkg::fetch_out_t fetch_out,
   output logic                  halted,
   output logic                  dump
);

   // Fetch address and returned word
   logic [`IMEM_AW-1:0] word_addr;
   fetch_pkg::instr_t   instr;
   // Same-cycle hazard level
   logic                raw_stall;

   instr_mem u_imem (
      .clk       (clk),
      .word_addr (word_addr),
      .rd_data   (instr),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data)
   );

   raw_hazard_detector u_raw (
      .clk       (clk),
      .arst_n    (arst_n),
      .instr     (instr),
      .dec_dst   (dec_dst),
      .raw_stall (raw_stall)
   );

   fetch u_fetch (
      .clk       (clk),
      .arst_n    (arst_n),
      .pc_src    (pc_src),
      .jump_pc   (jump_pc),
      .word_addr (word_addr),
      .instr     (instr),
      .raw_stall (raw_stall),
      .fetch_out (fetch_out),
      .halted    (halted),
      .dump      (dump)
   );

endmodule

//--- tb_fetch_subsystem.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the fetch stage top level
// Random program and stimulus, compared against a cycle model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_subsystem;

   localparam int          CLK_PERIOD  = 8;
   localparam int          RUN_CYCLES  = 2000;
   localparam logic [31:0] SEED        = 32'habdd_ab9b;
   localparam logic [`WORD_W-1:0] PC_MASK = `WORD_W'(2 * `IMEM_WORDS - 1);
   // Each reload needs at least a halt plus the dump delay
   localparam int MAX_RELOADS   = RUN_CYCLES / (`DUMP_DELAY + 1) + 1;
   localparam int RELOAD_CYCLES = `IMEM_WORDS + 3;
   localparam int LIMIT_CYCLES  = RUN_CYCLES + MAX_RELOADS * RELOAD_CYCLES;

   logic                  clk;
   logic                  arst_n;
   logic                  pc_src;
   logic [`WORD_W-1:0]    jump_pc;
   fetch_pkg::reg_dst_t   dec_dst;
   logic                  prog_we;
   logic [`IMEM_AW-1:0]   prog_addr;
   fetch_pkg::instr_t     prog_data;
   fetch_pkg::fetch_out_t fetch_out;
   logic                  halted;
   logic                  dump;

   // Model state
   logic [`WORD_W-1:0]    m_mem [`IMEM_WORDS];
   logic [`WORD_W-1:0]    m_pc;
   logic                  m_shadow;
   logic                  m_halted;
   int                    m_halt_age;
   fetch_pkg::reg_dst_t   m_hist [`RAW_WINDOW-1];
   fetch_pkg::fetch_out_t exp_out;
   logic                  exp_halted;
   logic                  exp_dump;

   // Run statistics
   int n_issue;
   int n_bubble;
   int n_redirect;
   int n_halt;
   int n_reload;

   fetch_subsystem uut (
      .clk       (clk),
      .arst_n    (arst_n),
      .pc_src    (pc_src),
      .jump_pc   (jump_pc),
      .dec_dst   (dec_dst),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .fetch_out (fetch_out),
      .halted    (halted),
      .dump      (dump)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Reporting and compares
   ////////////////////////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_fetch_out(input fetch_pkg::fetch_out_t exp,
                                  input fetch_pkg::fetch_out_t got);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] fetch_out expected %h got %h", exp, got));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s expected %h got %h", name, exp, got));
      end
   endtask

   task automatic check_outputs();
      check_fetch_out(exp_out, fetch_out);
      check_flag("halted", exp_halted, halted);
      check_flag("dump", exp_dump, dump);
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle model
   ////////////////////////////////////////////////////////////

   // Current decode destination plus the older window entries
   function automatic logic dst_hit(input logic [2:0] idx);
      logic hit;
      hit = dec_dst.valid && (dec_dst.idx == idx);
      for (int i = 0; i < `RAW_WINDOW-1; i++) begin
         hit = hit || (m_hist[i].valid && (m_hist[i].idx == idx));
      end
      return hit;
   endfunction

   task automatic model_reset();
      m_pc          = '0;
      m_shadow      = 1'b0;
      m_halted      = 1'b0;
      m_halt_age    = 0;
      for (int i = 0; i < `RAW_WINDOW-1; i++) begin
         m_hist[i] = '0;
      end
      exp_out.instr = fetch_pkg::instr_t'(`NOP_WORD);
      exp_out.pc_p2 = '0;
      exp_halted    = 1'b0;
      exp_dump      = 1'b0;
   endtask

   // One rising edge, using the inputs just driven
   task automatic model_step();
      logic [`WORD_W-1:0] w;
      logic [4:0]         op;
      logic               rs_used;
      logic               rt_used;
      logic               raw;
      logic               issue;
      w       = m_mem[m_pc[`IMEM_AW:1]];
      op      = w[15:11];
      rs_used = (op[4:2] != 3'b000) && !((op[4:2] == 3'b001) && !w[11]);
      rt_used = (op[4:1] == 4'b1101) || (op[4:2] == 3'b111);
      // rs in bits 10:8, rt in bits 7:5 for both formats
      raw     = (rs_used && dst_hit(w[10:8])) || (rt_used && dst_hit(w[7:5]));
      issue   = !(raw || m_shadow) && !m_halted;
      exp_out.instr = issue ? fetch_pkg::instr_t'(w) : fetch_pkg::instr_t'(`NOP_WORD);
      exp_out.pc_p2 = (m_pc + `WORD_W'(2)) & PC_MASK;
      if (issue) begin
         n_issue++;
         if (pc_src) begin
            n_redirect++;
         end
         m_pc = pc_src ? (jump_pc & PC_MASK) : exp_out.pc_p2;
      end else if (!m_halted) begin
         n_bubble++;
      end
      // Jump 001xx or branch 011xx leaves one shadow slot
      m_shadow = issue && ((op[4:2] == 3'b001) || (op[4:2] == 3'b011));
      if (m_halted) begin
         m_halt_age++;
      end else if (issue && (op == 5'b00000)) begin
         n_halt++;
         m_halted   = 1'b1;
         m_halt_age = 0;
      end
      exp_halted = m_halted;
      exp_dump   = m_halted && (m_halt_age >= `DUMP_DELAY);
      for (int i = `RAW_WINDOW-2; i > 0; i--) begin
         m_hist[i] = m_hist[i-1];
      end
      m_hist[0] = dec_dst;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   // Halt opcode kept to about one word in 128
   function automatic logic [`WORD_W-1:0] random_word();
      logic [31:0] r;
      r = $urandom();
      if ((r[15:11] == 5'b00000) && (r[17:16] != 2'b00)) begin
         r[15:11] = 5'b00001;
      end
      return r[15:0];
   endfunction

   task automatic drive_random();
      logic [31:0] r;
      r             = $urandom();
      pc_src        = (r[2:0] == 3'b000);
      // Even byte address inside the memory
      jump_pc       = {7'b0, r[10:3], 1'b0};
      dec_dst.valid = (r[12:11] == 2'b00);
      dec_dst.idx   = r[15:13];
   endtask

   // Called on a falling edge, returns on one with reset released
   task automatic reset_and_load();
      logic [`WORD_W-1:0] w;
      arst_n  = 1'b0;
      pc_src  = 1'b0;
      jump_pc = '0;
      // Valid destination through reset, history still starts empty
      dec_dst.valid = 1'b1;
      dec_dst.idx   = 3'($urandom());
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         w         = random_word();
         m_mem[i]  = w;
         prog_we   = 1'b1;
         prog_addr = i[`IMEM_AW-1:0];
         prog_data = fetch_pkg::instr_t'(w);
         @(negedge clk);
      end
      prog_we = 1'b0;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      model_reset();
      check_outputs();
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      arst_n     = 1'b0;
      pc_src     = 1'b0;
      jump_pc    = '0;
      dec_dst    = '0;
      prog_we    = 1'b0;
      prog_addr  = '0;
      prog_data  = '0;
      n_issue    = 0;
      n_bubble   = 0;
      n_redirect = 0;
      n_halt     = 0;
      n_reload   = 0;
      void'($urandom(SEED));
      reset_and_load();
      for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
         drive_random();
         model_step();
         @(negedge clk);
         check_outputs();
         // Start over with a fresh program once dump is seen
         if (exp_dump) begin
            n_reload++;
            reset_and_load();
         end
      end
      $display("Issues %0d, bubbles %0d, redirects %0d, halts %0d, reloads %0d",
               n_issue, n_bubble, n_redirect, n_halt, n_reload);
      $display("Simulation finished: PASS");
      $finish;
   end

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD * 2);
      fail_run("Timeout: the run did not reach its end in the expected time");
   end

endmodule

//--- flist.f
+incdir+.
fetch_pkg.sv
instr_mem.sv
raw_hazard_detector.sv
fetch.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_fetch_subsystem -f flist.f -o sim_fetch

output=$(./obj_dir/sim_fetch 2>&1) || true
echo "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
   exit 0
fi
exit 1
